// File: tb.f
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/decoder.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/pipeReg.sv
verilog/mips.sv
test/mips_checker.sv
test/tb_mips.sv

// File: test/mips_checker.sv
`timescale 1ns/1ns
`include "mips_config.svh"

module mips_checker (
	input logic              clk,
	input logic              reset,
	input logic [31:0]       instAddr,
	input pipePkg::memReqT   dataReq,
	input pipePkg::regWriteT grfWrite
);

	int failCount = 0; // Assertion failures so far

	// Pipeline is all nops while held in reset
	quietInReset: assert property (@(posedge clk)
		reset |=> (!grfWrite.we && dataReq.byteen == 4'h0))
		else begin
			failCount++;
			$error("writeback or store seen while in reset");
		end

	fetchAligned: assert property (@(posedge clk) disable iff (reset)
		instAddr[1:0] == 2'b00)
		else begin
			failCount++;
			$error("instAddr %h is not word aligned", instAddr);
		end

	// A store is one whole word at a word address
	wordStoresOnly: assert property (@(posedge clk) disable iff (reset)
		dataReq.byteen != 4'h0 |-> (dataReq.byteen == 4'hf && dataReq.addr[1:0] == 2'b00))
		else begin
			failCount++;
			$error("store with byteen %h at %h is not an aligned word", dataReq.byteen,
				dataReq.addr);
		end

	// First fetch after release
	startAtResetPc: assert property (@(posedge clk)
		$fell(reset) |-> instAddr == `RESET_PC)
		else begin
			failCount++;
			$error("first fetch at %h after reset", instAddr);
		end

endmodule

bind mips mips_checker chk (
	.clk(clk),
	.reset(reset),
	.instAddr(instAddr),
	.dataReq(dataReq),
	.grfWrite(grfWrite)
);

// File: test/tb_mips.sv
`timescale 1ns/1ns
`include "mips_config.svh"

module tb_mips;

	localparam int PROG_LEN    = 21;
	localparam int WB_COUNT    = 15;
	localparam int ST_COUNT    = 1;
	localparam int DMEM_WORDS  = 64;
	localparam int WATCHDOG_NS = (PROG_LEN + 20) * 10 * 2;

	logic              clk;
	logic              reset;
	logic [31:0]       instAddr;
	logic [31:0]       instRdata;
	logic [31:0]       dataRdata;
	pipePkg::memReqT   dataReq;
	pipePkg::regWriteT grfWrite;

	isaPkg::instrT     prog [PROG_LEN];
	logic [31:0]       dmem [DMEM_WORDS];
	logic [31:0]       initMem [DMEM_WORDS]; // Contents before the run
	pipePkg::regWriteT wbTable [WB_COUNT];
	int                gapTable [WB_COUNT];  // Cycles since previous writeback or release
	pipePkg::memReqT   stTable [ST_COUNT];
	int                nWb = 0;
	int                errors = 0;
	int                wbSeen = 0;
	int                stSeen = 0;
	logic              storePending = 1'b0;
	pipePkg::memReqT   pendReq;

	mips UUT (
		.clk(clk),
		.reset(reset),
		.instAddr(instAddr),
		.instRdata(instRdata),
		.dataReq(dataReq),
		.dataRdata(dataRdata),
		.grfWrite(grfWrite)
	);

	//////////////////////////////////////////////////////////////////////
	// Instruction encoders

	function automatic isaPkg::instrT encR(input isaPkg::functT funct,
		input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		return {isaPkg::SPECIAL, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic isaPkg::instrT encI(input isaPkg::opcodeT op,
		input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isaPkg::instrT encJ(input logic [31:0] target);
		return {isaPkg::J, target[27:2]};
	endfunction

	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - `RESET_PC) >> 2;
		if (addr >= `RESET_PC && idx < PROG_LEN) begin
			return prog[idx];
		end
		return 32'h0; // nop past the program
	endfunction

	task automatic loadProgram();
		prog[0]  = encI(isaPkg::ORI, 1, 0, 16'h1234);
		prog[1]  = encI(isaPkg::LUI, 2, 0, 16'habcd);
		prog[2]  = encR(isaPkg::ADDU, 3, 1, 2);  // $2 from memory stage
		prog[3]  = encR(isaPkg::SUBU, 4, 3, 1);
		prog[4]  = encI(isaPkg::SW, 3, 0, 16'd8);
		prog[5]  = encI(isaPkg::LW, 5, 0, 16'd8);
		prog[6]  = encR(isaPkg::ADDU, 6, 5, 1);  // Load-use
		prog[7]  = encI(isaPkg::LW, 7, 0, 16'd16);
		prog[8]  = encI(isaPkg::ORI, 8, 0, 16'h0001);
		prog[9]  = encR(isaPkg::ADDU, 9, 7, 8);
		prog[10] = encI(isaPkg::BEQ, 9, 9, 16'd2); // Taken once $9 is ready
		prog[11] = encI(isaPkg::ORI, 10, 0, 16'h00aa);
		prog[12] = encI(isaPkg::ORI, 11, 0, 16'h00bb);
		prog[13] = encI(isaPkg::ORI, 12, 0, 16'h00cc);
		prog[14] = encI(isaPkg::BEQ, 2, 1, 16'd5); // Not taken
		prog[15] = encI(isaPkg::ORI, 13, 0, 16'h00dd);
		prog[16] = encJ(`RESET_PC + 32'h4c);
		prog[17] = encI(isaPkg::ORI, 14, 0, 16'h00ee);
		prog[18] = encI(isaPkg::ORI, 15, 0, 16'h00ff);
		prog[19] = encI(isaPkg::ORI, 0, 0, 16'h5555);
		prog[20] = encR(isaPkg::ADDU, 16, 0, 1);
	endtask

	task automatic addWrite(input logic [31:0] offset, input logic [4:0] dst,
		input logic [31:0] value, input int gap);
		wbTable[nWb] = '{we: 1'b1, addr: dst, data: value, pc: `RESET_PC + offset};
		gapTable[nWb] = gap;
		nWb++;
	endtask

	// Writebacks in order, skipped instructions left out
	task automatic buildExpect();
		addWrite(32'h00, 1, 32'h0000_1234, 5); // Fetched right at release
		addWrite(32'h04, 2, 32'habcd_0000, 1);
		addWrite(32'h08, 3, 32'habcd_1234, 1);
		addWrite(32'h0c, 4, 32'habcd_0000, 1);
		addWrite(32'h14, 5, 32'habcd_1234, 2); // sw leaves a gap
		addWrite(32'h18, 6, 32'habcd_2468, 2); // One stall cycle
		addWrite(32'h1c, 7, initMem[4], 1);
		addWrite(32'h20, 8, 32'h0000_0001, 1);
		addWrite(32'h24, 9, initMem[4] + 32'd1, 1);
		addWrite(32'h2c, 10, 32'h0000_00aa, 3); // beq plus its stall
		addWrite(32'h34, 12, 32'h0000_00cc, 1);
		addWrite(32'h3c, 13, 32'h0000_00dd, 2);
		addWrite(32'h44, 14, 32'h0000_00ee, 2);
		addWrite(32'h4c, 0, 32'h0000_5555, 1);
		addWrite(32'h50, 16, 32'h0000_1234, 1); // $0 reads as zero
		stTable[0] = '{addr: 32'd8, wdata: 32'habcd_1234, byteen: 4'hf,
			pc: `RESET_PC + 32'h10};
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic checkWrite(input pipePkg::regWriteT got, input pipePkg::regWriteT exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: writeback pc %h $%0d=%h, expected pc %h $%0d=%h",
				$time, got.pc, got.addr, got.data, exp.pc, exp.addr, exp.data);
		end
	endtask

	task automatic checkStore(input pipePkg::memReqT got, input pipePkg::memReqT exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: store pc %h [%h]=%h be %h, expected pc %h [%h]=%h be %h",
				$time, got.pc, got.addr, got.wdata, got.byteen,
				exp.pc, exp.addr, exp.wdata, exp.byteen);
		end
	endtask

	task automatic checkGap(input int got, input int exp, input logic [31:0] pc);
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED at %0t: pc %h wrote back %0d cycles after the last, expected %0d",
				$time, pc, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Clock, memories, monitors

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Combinational memories answer 1 ns after the edge
	always @(posedge clk) begin
		#1;
		if (storePending) begin
			dmem[pendReq.addr[7:2]] = pendReq.wdata;
			storePending = 1'b0;
		end
		instRdata = fetchWord(instAddr);
		dataRdata = dmem[dataReq.addr[7:2]];
	end

	always @(negedge clk) begin
		if (!reset && dataReq.byteen != 4'h0) begin
			if (stSeen < ST_COUNT) begin
				checkStore(dataReq, stTable[stSeen]);
			end else begin
				errors++;
				$display("Unexpected store to %h from pc %h", dataReq.addr, dataReq.pc);
			end
			stSeen++;
			pendReq = dataReq;
			storePending = 1'b1; // Lands on the next rising edge
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: %0d of %0d writebacks seen after %0d ns", wbSeen, WB_COUNT,
			WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int cycles;
		reset = 1'b1;
		instRdata = 32'h0;
		dataRdata = 32'h0;
		void'($urandom(5526));
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = $urandom;
			initMem[i] = dmem[i];
		end
		loadProgram();
		buildExpect();
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;

		for (int i = 0; i < WB_COUNT; i++) begin
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
			end while (!grfWrite.we);
			checkWrite(grfWrite, wbTable[i]);
			checkGap(cycles, gapTable[i], wbTable[i].pc);
			wbSeen++;
		end

		// Nothing more may retire once the program is done
		repeat (10) begin
			@(negedge clk);
			if (grfWrite.we) begin
				errors++;
				$display("Extra writeback to $%0d from pc %h", grfWrite.addr, grfWrite.pc);
			end
		end
		if (stSeen != ST_COUNT) begin
			errors++;
			$display("Saw %0d stores where %0d were expected", stSeen, ST_COUNT);
		end

		$display("Writebacks %0d, stores %0d, errors %0d, assertion failures %0d",
			wbSeen, stSeen, errors, UUT.chk.failCount);
		if (errors == 0 && UUT.chk.failCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ns

module decoder (
	input  isaPkg::instrT instr,
	output pipePkg::ctrlT ctrl
);

	always_comb begin
		ctrl = '0; // Unknown encodings fall out as a nop
		case (instr.op)
			isaPkg::SPECIAL: begin
				case (instr.funct)
					isaPkg::ADDU: begin
						ctrl.regWrite = 1'b1;
						ctrl.dstSel   = 1'b1;
						ctrl.aluOp    = pipePkg::ADD;
						ctrl.usesRs   = 1'b1;
						ctrl.usesRt   = 1'b1;
					end
					isaPkg::SUBU: begin
						ctrl.regWrite = 1'b1;
						ctrl.dstSel   = 1'b1;
						ctrl.aluOp    = pipePkg::SUB;
						ctrl.usesRs   = 1'b1;
						ctrl.usesRt   = 1'b1;
					end
					default: ;
				endcase
			end
			isaPkg::ORI: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluOp     = pipePkg::OR;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExt   = 1'b1;
				ctrl.usesRs    = 1'b1;
			end
			isaPkg::LUI: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluOp     = pipePkg::LUI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExt   = 1'b1;
			end
			isaPkg::LW: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1; // Base plus signed offset
				ctrl.memRead   = 1'b1;
				ctrl.usesRs    = 1'b1;
			end
			isaPkg::SW: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite  = 1'b1;
				ctrl.usesRs    = 1'b1;
				ctrl.usesRt    = 1'b1; // Store data
			end
			isaPkg::BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.usesRs = 1'b1;
				ctrl.usesRt = 1'b1;
			end
			isaPkg::J: ctrl.jump = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
	input  logic [4:0]      rsD,
	input  logic [4:0]      rtD,
	input  logic            usesRsD,
	input  logic            usesRtD,
	input  logic            branchD,
	input  logic [4:0]      rsE,
	input  logic [4:0]      rtE,
	input  logic [4:0]      dstE,
	input  logic            regWriteE,
	input  logic            memReadE,
	input  logic [4:0]      dstM,
	input  logic            regWriteM,
	input  logic            memReadM,
	input  logic [4:0]      dstW,
	input  logic            regWriteW,
	output logic            stall,
	output pipePkg::fwdSelT fwdRsD,
	output pipePkg::fwdSelT fwdRtD,
	output pipePkg::fwdSelT fwdRsE,
	output pipePkg::fwdSelT fwdRtE
);

	logic writesE, writesM, writesW;
	logic aluM;       // Memory stage result ready to forward
	logic needRs, needRt;
	logic hitE, hitM; // Decode depends on that stage

	assign writesE = regWriteE && (dstE != 5'd0);
	assign writesM = regWriteM && (dstM != 5'd0);
	assign writesW = regWriteW && (dstW != 5'd0);
	assign aluM    = writesM && !memReadM;

	assign needRs = usesRsD && (rsD != 5'd0);
	assign needRt = usesRtD && (rtD != 5'd0);

	assign hitE = writesE && ((needRs && rsD == dstE) || (needRt && rtD == dstE));
	assign hitM = writesM && ((needRs && rsD == dstM) || (needRt && rtD == dstM));

	// Load-use, or branch waiting on execute or on a load in memory
	assign stall = (hitE && (memReadE || branchD)) || (hitM && memReadM && branchD);

	// Writeback in decode is covered by the register file bypass
	assign fwdRsD = (needRs && aluM && rsD == dstM) ? pipePkg::FROM_MEM : pipePkg::NONE;
	assign fwdRtD = (needRt && aluM && rtD == dstM) ? pipePkg::FROM_MEM : pipePkg::NONE;

	function automatic pipePkg::fwdSelT pickE(input logic [4:0] src);
		if (aluM && src == dstM) begin
			return pipePkg::FROM_MEM; // Newest value wins
		end else if (writesW && src == dstW) begin
			return pipePkg::FROM_WB;
		end
		return pipePkg::NONE;
	endfunction

	assign fwdRsE = pickE(rsE);
	assign fwdRtE = pickE(rtE);

endmodule

// File: verilog/isaPkg.sv
package isaPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		SPECIAL = 6'h00, // R-type with the op in funct
		J       = 6'h02,
		BEQ     = 6'h04,
		ORI     = 6'h0d,
		LUI     = 6'h0f,
		LW      = 6'h23,
		SW      = 6'h2b
	} opcodeT;

	// Funct codes under SPECIAL
	typedef enum logic [5:0] {
		ADDU = 6'h21,
		SUBU = 6'h23
	} functT;

	// One instruction word in R-type layout
	// Immediate is bits 15:0, jump index bits 25:0
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrT;

endpackage

// File: verilog/mips.sv
`timescale 1ns/1ns
`include "mips_config.svh"

module mips (
	input  logic              clk,
	input  logic              reset,
	output logic [31:0]       instAddr,
	input  logic [31:0]       instRdata,
	output pipePkg::memReqT   dataReq,
	input  logic [31:0]       dataRdata,
	output pipePkg::regWriteT grfWrite
);

	// Operand pick shared by branch compare and ALU inputs
	function automatic logic [`XLEN-1:0] fwdMux(
		input pipePkg::fwdSelT  sel,
		input logic [`XLEN-1:0] regVal,
		input logic [`XLEN-1:0] memVal,
		input logic [`XLEN-1:0] wbVal
	);
		case (sel)
			pipePkg::FROM_MEM: return memVal;
			pipePkg::FROM_WB:  return wbVal;
			default:           return regVal;
		endcase
	endfunction

	pipePkg::ifIdT   ifIdD, ifIdQ;
	pipePkg::idExT   idExD, idExQ;
	pipePkg::exMemT  exMemD, exMemQ;
	pipePkg::memWbT  memWbD, memWbQ;
	logic            stall;
	pipePkg::fwdSelT fwdRsD, fwdRtD, fwdRsE, fwdRtE;

	//////////////////////////////////////////////////////////////////////
	// Fetch

	logic [31:0] pc, nextPc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	assign instAddr = pc;

	always_comb begin
		ifIdD.pc    = pc;
		ifIdD.instr = instRdata;
	end

	pipeReg #(.payloadT(pipePkg::ifIdT)) ifIdReg (
		.clk(clk),
		.reset(reset),
		.en(!stall),  // Hold the instruction in decode
		.clr(1'b0),   // Delay slot is never squashed
		.d(ifIdD),
		.q(ifIdQ)
	);

	//////////////////////////////////////////////////////////////////////
	// Decode, branch resolution

	pipePkg::ctrlT    ctrlD;
	logic [`XLEN-1:0] rsValD, rtValD, rsCmp, rtCmp, immD;
	logic [15:0]      imm16;
	logic [31:0]      slotPc;

	decoder dec (
		.instr(ifIdQ.instr),
		.ctrl(ctrlD)
	);

	regFile grf (
		.clk(clk),
		.reset(reset),
		.rs(ifIdQ.instr.rs),
		.rt(ifIdQ.instr.rt),
		.rsVal(rsValD),
		.rtVal(rtValD),
		.wr(grfWrite)
	);

	assign imm16  = ifIdQ.instr[15:0];
	assign immD   = ctrlD.zeroExt ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
	assign rsCmp  = fwdMux(fwdRsD, rsValD, exMemQ.aluOut, memWbQ.value);
	assign rtCmp  = fwdMux(fwdRtD, rtValD, exMemQ.aluOut, memWbQ.value);
	assign slotPc = ifIdQ.pc + `DELAY_SLOT_OFFSET;

	always_comb begin
		if (ctrlD.jump) begin
			nextPc = {slotPc[31:28], ifIdQ.instr[25:0], 2'b00};
		end else if (ctrlD.branch && rsCmp == rtCmp) begin
			nextPc = slotPc + {{14{imm16[15]}}, imm16, 2'b00};
		end else begin
			nextPc = pc + 32'd4;
		end
	end

	always_comb begin
		idExD.pc    = ifIdQ.pc;
		idExD.ctrl  = ctrlD;
		idExD.rs    = ifIdQ.instr.rs;
		idExD.rt    = ifIdQ.instr.rt;
		idExD.dst   = ctrlD.dstSel ? ifIdQ.instr.rd : ifIdQ.instr.rt;
		idExD.rsVal = rsValD;
		idExD.rtVal = rtValD;
		idExD.imm   = immD;
	end

	hazardUnit hazard (
		.rsD(ifIdQ.instr.rs),
		.rtD(ifIdQ.instr.rt),
		.usesRsD(ctrlD.usesRs),
		.usesRtD(ctrlD.usesRt),
		.branchD(ctrlD.branch),
		.rsE(idExQ.rs),
		.rtE(idExQ.rt),
		.dstE(idExQ.dst),
		.regWriteE(idExQ.ctrl.regWrite),
		.memReadE(idExQ.ctrl.memRead),
		.dstM(exMemQ.dst),
		.regWriteM(exMemQ.ctrl.regWrite),
		.memReadM(exMemQ.ctrl.memRead),
		.dstW(memWbQ.dst),
		.regWriteW(memWbQ.regWrite),
		.stall(stall),
		.fwdRsD(fwdRsD),
		.fwdRtD(fwdRtD),
		.fwdRsE(fwdRsE),
		.fwdRtE(fwdRtE)
	);

	pipeReg #(.payloadT(pipePkg::idExT)) idExReg (
		.clk(clk),
		.reset(reset),
		.en(1'b1),
		.clr(stall), // Bubble behind a stalled decode
		.d(idExD),
		.q(idExQ)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute

	logic [`XLEN-1:0] srcA, rtFwd, srcB, aluOut;

	assign srcA  = fwdMux(fwdRsE, idExQ.rsVal, exMemQ.aluOut, memWbQ.value);
	assign rtFwd = fwdMux(fwdRtE, idExQ.rtVal, exMemQ.aluOut, memWbQ.value);
	assign srcB  = idExQ.ctrl.aluSrcImm ? idExQ.imm : rtFwd;

	always_comb begin
		case (idExQ.ctrl.aluOp)
			pipePkg::ADD: aluOut = srcA + srcB;
			pipePkg::SUB: aluOut = srcA - srcB;
			pipePkg::OR:  aluOut = srcA | srcB;
			default:      aluOut = {srcB[15:0], 16'b0}; // lui
		endcase
	end

	always_comb begin
		exMemD.pc       = idExQ.pc;
		exMemD.ctrl     = idExQ.ctrl;
		exMemD.dst      = idExQ.dst;
		exMemD.aluOut   = aluOut;
		exMemD.storeVal = rtFwd;
	end

	pipeReg #(.payloadT(pipePkg::exMemT)) exMemReg (
		.clk(clk),
		.reset(reset),
		.en(1'b1),
		.clr(1'b0),
		.d(exMemD),
		.q(exMemQ)
	);

	//////////////////////////////////////////////////////////////////////
	// Memory and writeback

	always_comb begin
		dataReq.addr   = exMemQ.aluOut;
		dataReq.wdata  = exMemQ.storeVal;
		dataReq.byteen = exMemQ.ctrl.memWrite ? 4'hf : 4'h0; // Word stores only
		dataReq.pc     = exMemQ.pc;
	end

	always_comb begin
		memWbD.pc       = exMemQ.pc;
		memWbD.regWrite = exMemQ.ctrl.regWrite;
		memWbD.dst      = exMemQ.dst;
		memWbD.value    = exMemQ.ctrl.memRead ? dataRdata : exMemQ.aluOut;
	end

	pipeReg #(.payloadT(pipePkg::memWbT)) memWbReg (
		.clk(clk),
		.reset(reset),
		.en(1'b1),
		.clr(1'b0),
		.d(memWbD),
		.q(memWbQ)
	);

	// Trace port doubles as the register file write
	always_comb begin
		grfWrite.we   = memWbQ.regWrite;
		grfWrite.addr = memWbQ.dst;
		grfWrite.data = memWbQ.value;
		grfWrite.pc   = memWbQ.pc;
	end

endmodule

// File: verilog/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_3000

// Register file geometry
`define NUM_REGS 32
`define XLEN 32 // Data path width

// Delay slot sits one word past the branch or jump
`define DELAY_SLOT_OFFSET 32'd4

`endif

// File: verilog/pipePkg.sv
`include "mips_config.svh"

package pipePkg;

	typedef enum logic [1:0] {ADD, SUB, OR, LUI} aluOpT;

	typedef struct packed {
		logic  regWrite;
		logic  dstSel;    // 1 selects rd, 0 selects rt
		aluOpT aluOp;
		logic  aluSrcImm;
		logic  zeroExt;
		logic  memRead;
		logic  memWrite;
		logic  branch;
		logic  jump;
		logic  usesRs;
		logic  usesRt;
	} ctrlT;

	typedef enum logic [1:0] {NONE = 2'd0, FROM_MEM = 2'd1, FROM_WB = 2'd2} fwdSelT;

	//////////////////////////////////////////////////////////////////////
	// Stage boundary payloads

	typedef struct packed {
		logic [31:0]   pc;
		isaPkg::instrT instr;
	} ifIdT;

	typedef struct packed {
		logic [31:0]      pc;
		ctrlT             ctrl;
		logic [4:0]       rs;
		logic [4:0]       rt;
		logic [4:0]       dst;
		logic [`XLEN-1:0] rsVal;
		logic [`XLEN-1:0] rtVal;
		logic [`XLEN-1:0] imm;   // Already extended
	} idExT;

	typedef struct packed {
		logic [31:0]      pc;
		ctrlT             ctrl;
		logic [4:0]       dst;
		logic [`XLEN-1:0] aluOut;
		logic [`XLEN-1:0] storeVal;
	} exMemT;

	typedef struct packed {
		logic [31:0]      pc;
		logic             regWrite;
		logic [4:0]       dst;
		logic [`XLEN-1:0] value;
	} memWbT;

	//////////////////////////////////////////////////////////////////////
	// External ports

	typedef struct packed {
		logic [31:0]      addr;
		logic [`XLEN-1:0] wdata;
		logic [3:0]       byteen; // All ones on a store
		logic [31:0]      pc;
	} memReqT;

	typedef struct packed {
		logic             we;
		logic [4:0]       addr;
		logic [`XLEN-1:0] data;
		logic [31:0]      pc;
	} regWriteT;

endpackage

// File: verilog/pipeReg.sv
`timescale 1ns/1ns

module pipeReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    en,
	input  logic    clr,
	input  payloadT d,
	output payloadT q
);

	// All-zero payload is a nop at every boundary
	always_ff @(posedge clk) begin
		if (reset || clr) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ns
`include "mips_config.svh"

module regFile (
	input  logic              clk,
	input  logic              reset,
	input  logic [4:0]        rs,
	input  logic [4:0]        rt,
	output logic [31:0]       rsVal,
	output logic [31:0]       rtVal,
	input  pipePkg::regWriteT wr
);

	logic [`XLEN-1:0] regs [`NUM_REGS];
	logic             wrLive; // Write that actually lands

	assign wrLive = wr.we && (wr.addr != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Same-cycle write shows through to decode
	assign rsVal = (wrLive && wr.addr == rs) ? wr.data : regs[rs];
	assign rtVal = (wrLive && wr.addr == rt) ? wr.data : regs[rt];

endmodule
